// File: project.f
+incdir+common
common/gpu_pkg.sv
gpu_inst/gpu_inst_unit.sv
hdl/warp_ctl_fifo.sv
warp_sched/warp_sched_ctl.sv
hdl/gpu_ctl_top.sv
sim/gpu_ctl_assert.sv
sim/gpu_ctl_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the warp-control testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
	--top-module gpu_ctl_tb -Mdir obj_dir -f project.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vgpu_ctl_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
	exit 1
fi
exit 0

// File: sim/gpu_ctl_tb.sv
`timescale 1ns/10ps
`include "gpu_macros.svh"

module gpu_ctl_tb
	import gpu_pkg::*;
();
	localparam int RESET_CYCLES = 10;
	// about 60 instructions, each far below 30 cycles even behind a full FIFO
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + 60 * 30;

	logic                          clk;
	logic                          arst_n;
	logic                          inst_valid;
	logic                          inst_ready;
	gpu_inst_req_t                 inst_req;
	logic                          hold;
	thread_mask_t [`NUM_WARPS-1:0] thread_masks;
	warp_mask_t                    active_warps;
	warp_mask_t                    stall_mask;
	word_t                         spawn_pc;
	word_t                         join_pc;
	logic                          halted;

	integer seed = 32'h936cadc3;
	int     errors = 0;
	int     checks = 0;
	string  test_name = "reset";
	event   accepted_ev;

	// expected scheduler state
	thread_mask_t m_masks [`NUM_WARPS] = '{default: '0};
	thread_mask_t m_save_mask [`NUM_WARPS];
	word_t        m_save_pc [`NUM_WARPS];
	warp_mask_t   m_save_valid = '0;
	warp_mask_t   m_active = warp_mask_t'(1);
	warp_mask_t   m_stall = '0;
	word_t        m_spawn_pc = '0;
	word_t        m_join_pc = '0;
	logic         m_halted = 1'b0;
	int           m_bar_count [`NUM_BARRIERS] = '{default: 0};
	warp_mask_t   m_bar_waiters [`NUM_BARRIERS] = '{default: '0};

	gpu_ctl_top i_gpu_ctl_top (.*);

	initial begin
		clk = 1'b0;
		forever begin
			#2 clk = ~clk;
		end
	end

	function automatic word_t rand_word();
		return $random(seed);
	endfunction

	function automatic thread_mask_t rand_mask();
		word_t v;
		v = rand_word();
		return v[`NUM_THREADS-1:0];
	endfunction

	// every thread gets operand a0
	function automatic gpu_inst_req_t make_req(input gpu_op_t op, input int w,
	                                           input thread_mask_t valid, input word_t a0,
	                                           input word_t rd2);
		gpu_inst_req_t r;
		r.valid    = valid;
		r.warp_num = warp_num_t'(w);
		r.op       = op;
		for (int t = 0; t < `NUM_THREADS; t++) begin
			r.a_reg_data[t] = a0;
		end
		r.rd2     = rd2;
		r.pc_next = rand_word();
		return r;
	endfunction

	// predicates of 0, 1 or 2 per thread, only 1 takes the branch
	function automatic gpu_inst_req_t with_split_ops(input gpu_inst_req_t r);
		for (int t = 0; t < `NUM_THREADS; t++) begin
			r.a_reg_data[t] = rand_word() % 3;
		end
		return r;
	endfunction

	function automatic void model_apply(input gpu_inst_req_t r);
		word_t        n;
		thread_mask_t use_mask;
		warp_mask_t   wbit;
		int           w;
		int           bid;
		if (m_halted) return;
		n    = r.a_reg_data[0];
		w    = int'(r.warp_num);
		wbit = '0;
		wbit[w] = 1'b1;
		case (r.op)
			op_tmc: if (r.valid != '0) begin
				for (int t = 0; t < `NUM_THREADS; t++) begin
					m_masks[w][t] = (t < n);
				end
				if (m_masks[w] == '0) m_halted = 1'b1;
			end
			op_wspawn: begin
				for (int i = 0; i < `NUM_WARPS; i++) begin
					m_active[i] = (i < n) || (i == 0);
				end
				m_spawn_pc = r.rd2;
			end
			op_split: begin
				for (int t = 0; t < `NUM_THREADS; t++) begin
					use_mask[t] = r.valid[t] && (r.a_reg_data[t] == 32'd1);
				end
				if ($countones(r.valid) > 1 && use_mask != '0 && use_mask != '1) begin
					m_masks[w]      = use_mask;
					m_save_mask[w]  = r.valid & ~use_mask;
					m_save_pc[w]    = r.pc_next;
					m_save_valid[w] = 1'b1;
				end
			end
			op_join: if (m_save_valid[w]) begin
				m_masks[w]      = m_save_mask[w];
				m_join_pc       = m_save_pc[w];
				m_save_valid[w] = 1'b0;
			end
			op_bar: begin
				bid = int'(n % `NUM_BARRIERS);
				m_bar_count[bid]++;
				m_bar_waiters[bid] |= wbit;
				m_stall |= wbit;
				// rd2 is the number of warps that meet at the barrier
				if (m_bar_count[bid] == int'(r.rd2)) begin
					m_stall &= ~m_bar_waiters[bid];
					m_bar_waiters[bid] = '0;
					m_bar_count[bid]   = 0;
				end
			end
			default: ;
		endcase
	endfunction

	task automatic check_mask(input string what, input thread_mask_t exp, input thread_mask_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("ERROR %s: %s expected %h actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic check_warps(input string what, input warp_mask_t exp, input warp_mask_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("ERROR %s: %s expected %h actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic check_word(input string what, input word_t exp, input word_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("ERROR %s: %s expected %h actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic check_flag(input string what, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("ERROR %s: %s expected %b actual %b", test_name, what, exp, act);
		end
	endtask

	task automatic compare_all();
		for (int w = 0; w < `NUM_WARPS; w++) begin
			check_mask($sformatf("thread mask %0d", w), m_masks[w], thread_masks[w]);
		end
		check_warps("active_warps", m_active, active_warps);
		check_warps("stall_mask", m_stall, stall_mask);
		check_word("spawn_pc", m_spawn_pc, spawn_pc);
		check_word("join_pc", m_join_pc, join_pc);
		check_flag("halted", m_halted, halted);
	endtask

	task automatic wait_drained();
		@(negedge clk);
		while (hold || i_gpu_ctl_top.rec_valid) begin
			@(negedge clk);
		end
	endtask

	task automatic send_inst(input gpu_inst_req_t r, input bit checked);
		if (checked) wait_drained();
		else @(negedge clk);
		inst_valid = 1'b1;
		inst_req   = r;
		while (!inst_ready) begin
			@(negedge clk);
		end
		@(posedge clk);
		model_apply(r);
		if (checked) -> accepted_ev;
		@(negedge clk);
		inst_valid = 1'b0;
	endtask

	// outputs settle one cycle after the accept edge
	initial begin
		forever begin
			@(accepted_ev);
			@(posedge clk);
			@(negedge clk);
			compare_all();
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles, DUT stopped making progress",
		         WATCHDOG_CYCLES);
		$display("Test FAILED");
		$finish;
	end

	initial begin
		gpu_inst_req_t r;
		word_t         v;
		arst_n     = 1'b0;
		hold       = 1'b0;
		inst_valid = 1'b0;
		inst_req   = '0;
		m_masks[0] = '1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		@(negedge clk);
		compare_all();
		check_flag("inst_ready", 1'b1, inst_ready);

		test_name = "tmc";
		for (int n = 0; n <= 5; n++) begin
			r = make_req(op_tmc, 0, rand_mask(), word_t'(n), 32'd0);
			// zero count only with an empty mask, halting comes last
			if (n == 0) r.valid = '0;
			send_inst(r, 1'b1);
		end
		send_inst(make_req(op_tmc, 0, 4'h0, 32'd2, 32'd0), 1'b1);
		send_inst(make_req(op_tmc, 0, 4'hf, 32'd4, 32'd0), 1'b1);

		test_name = "wspawn";
		repeat (6) begin
			send_inst(make_req(op_wspawn, 0, 4'hf, rand_word() % 6, rand_word()), 1'b1);
		end

		test_name = "split_join";
		for (int i = 0; i < 8; i++) begin
			r = with_split_ops(make_req(op_split, i % 4, rand_mask(), 32'd0, 32'd0));
			send_inst(r, 1'b1);
			r.op = op_join;
			send_inst(r, 1'b1);
			// second join finds no save
			send_inst(r, 1'b1);
		end
		send_inst(make_req(op_split, 1, 4'hf, 32'd1, 32'd0), 1'b1);
		send_inst(make_req(op_join, 1, 4'hf, 32'd0, 32'd0), 1'b1);
		send_inst(make_req(op_split, 2, 4'hf, 32'd0, 32'd0), 1'b1);
		// a uniform split leaves no save for the join
		send_inst(make_req(op_join, 2, 4'hf, 32'd0, 32'd0), 1'b1);

		test_name = "barrier";
		for (int w = 1; w < `NUM_WARPS; w++) begin
			send_inst(make_req(op_bar, w, 4'hf, 32'd2, 32'd4), 1'b1);
		end
		send_inst(make_req(op_bar, 0, 4'hf, 32'd2, 32'd4), 1'b1);

		test_name = "back_pressure";
		wait_drained();
		hold = 1'b1;
		for (int i = 0; i < `CTL_FIFO_DEPTH; i++) begin
			v = rand_word();
			// counts of 1 to 5 keep the core running
			r = make_req(gpu_op_t'({1'b0, v[1:0]}), int'(v[3:2]), rand_mask(),
			             32'd1 + word_t'(v[10:8] % 3'd5), rand_word());
			if (r.op == op_split) r = with_split_ops(r);
			send_inst(r, 1'b0);
		end
		check_flag("inst_ready with full FIFO", 1'b0, inst_ready);
		hold = 1'b0;
		wait_drained();
		compare_all();

		test_name = "halt";
		send_inst(make_req(op_tmc, 1, 4'hf, 32'd0, 32'd0), 1'b1);
		for (int i = 0; i < `CTL_FIFO_DEPTH; i++) begin
			send_inst(make_req(op_wspawn, 0, 4'hf, 32'd3, rand_word()), 1'b0);
		end
		check_flag("inst_ready while halted", 1'b0, inst_ready);
		repeat (4) @(negedge clk);
		compare_all();

		$display("checks: %0d  errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// File: sim/gpu_ctl_assert.sv
`timescale 1ns/10ps

module gpu_ctl_assert
	import gpu_pkg::*;
(
	input logic       clk,
	input logic       arst_n,
	input logic       rec_valid,
	input logic       rec_ready,
	input warp_ctl_t  rec,
	input warp_mask_t active_warps,
	input warp_mask_t stall_mask,
	input logic       halted
);
	// the core stays frozen after ebreak
	a_frozen_halted: assert property (@(posedge clk) disable iff (!arst_n)
		halted |=> halted && $stable(active_warps) && $stable(stall_mask))
		else $error("scheduler state changed while the core is halted");

	a_warp0_active: assert property (@(posedge clk) disable iff (!arst_n)
		active_warps[0])
		else $error("warp 0 dropped out of active_warps");

	// stall bits only come from a consumed barrier record
	a_stall_on_bar: assert property (@(posedge clk) disable iff (!arst_n)
		(|(stall_mask & ~$past(stall_mask))) |-> $past(rec_valid && rec_ready && rec.is_barrier))
		else $error("stall bit rose without a barrier record");

endmodule

bind warp_sched_ctl gpu_ctl_assert i_gpu_ctl_assert (
	.clk          (clk),
	.arst_n       (arst_n),
	.rec_valid    (rec_valid),
	.rec_ready    (rec_ready),
	.rec          (rec),
	.active_warps (active_warps),
	.stall_mask   (stall_mask),
	.halted       (halted)
);

// File: hdl/gpu_ctl_top.sv
`timescale 1ns/10ps
`include "gpu_macros.svh"

module gpu_ctl_top
	import gpu_pkg::*;
(
	input  logic                           clk,
	input  logic                           arst_n,
	input  logic                           inst_valid,
	output logic                           inst_ready,
	input  gpu_inst_req_t                  inst_req,
	input  logic                           hold,
	output thread_mask_t [`NUM_WARPS-1:0] thread_masks,
	output warp_mask_t                     active_warps,
	output warp_mask_t                     stall_mask,
	output word_t                          spawn_pc,
	output word_t                          join_pc,
	output logic                           halted
);
	warp_ctl_t dec_rec;
	warp_ctl_t rec;
	logic      rec_valid;
	logic      rec_ready;

	// decode is combinational, the record is written on the accept edge
	gpu_inst_unit i_gpu_inst_unit (
		.req (inst_req),
		.ctl (dec_rec)
	);

	warp_ctl_fifo #(
		.DEPTH (`CTL_FIFO_DEPTH)
	) i_warp_ctl_fifo (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (inst_valid),
		.in_ready  (inst_ready),
		.in_rec    (dec_rec),
		.out_valid (rec_valid),
		.out_ready (rec_ready),
		.out_rec   (rec)
	);

	warp_sched_ctl i_warp_sched_ctl (
		.clk          (clk),
		.arst_n       (arst_n),
		.hold         (hold),
		.rec_valid    (rec_valid),
		.rec          (rec),
		.rec_ready    (rec_ready),
		.thread_masks (thread_masks),
		.active_warps (active_warps),
		.stall_mask   (stall_mask),
		.spawn_pc     (spawn_pc),
		.join_pc      (join_pc),
		.halted       (halted)
	);

endmodule

// File: warp_sched/warp_sched_ctl.sv
`timescale 1ns/10ps
`include "gpu_macros.svh"

module warp_sched_ctl
	import gpu_pkg::*;
(
	input  logic                           clk,
	input  logic                           arst_n,
	input  logic                           hold,
	input  logic                           rec_valid,
	input  warp_ctl_t                      rec,
	output logic                           rec_ready,
	output thread_mask_t [`NUM_WARPS-1:0] thread_masks,
	output warp_mask_t                     active_warps,
	output warp_mask_t                     stall_mask,
	output word_t                          spawn_pc,
	output word_t                          join_pc,
	output logic                           halted
);
	// one-level divergence save per warp
	warp_mask_t       save_valid;
	thread_mask_t     save_mask [`NUM_WARPS];
	word_t            save_pc [`NUM_WARPS];

	// arrivals and waiting warps per barrier id
	logic [NW_BITS:0] bar_count [`NUM_BARRIERS];
	warp_mask_t       bar_waiters [`NUM_BARRIERS];

	logic             fire;
	warp_mask_t       warp_bit;
	logic             bar_release;
	logic             do_split;

	// nothing leaves the FIFO after ebreak
	assign rec_ready = !hold && !halted;
	assign fire      = rec_valid && rec_ready;
	assign warp_bit  = warp_mask_t'(1) << rec.warp_num;
	assign do_split  = rec.is_split && !rec.dont_split;

	// this arrival is the last one when num_warps others already wait
	assign bar_release = (bar_count[rec.barrier_id] == rec.num_warps);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			thread_masks <= '0;
			thread_masks[0] <= '1;
			active_warps <= warp_mask_t'(1);
			stall_mask   <= '0;
			spawn_pc     <= '0;
			join_pc      <= '0;
			halted       <= 1'b0;
			save_valid   <= '0;
			for (int b = 0; b < `NUM_BARRIERS; b++) begin
				bar_count[b]   <= '0;
				bar_waiters[b] <= '0;
			end
		end else if (fire) begin
			// tmc
			if (rec.change_mask) begin
				thread_masks[rec.warp_num] <= rec.thread_mask;
				if (rec.ebreak) halted <= 1'b1;
			end

			// wspawn keeps warp 0 running
			if (rec.wspawn) begin
				active_warps <= rec.wspawn_new_active | warp_mask_t'(1);
				spawn_pc     <= rec.wspawn_pc;
			end

			if (do_split) begin
				thread_masks[rec.warp_num] <= rec.split_new_mask;
				save_valid[rec.warp_num]   <= 1'b1;
			end

			// join without a save is a no-op
			if (rec.is_join && save_valid[rec.warp_num]) begin
				thread_masks[rec.warp_num] <= save_mask[rec.warp_num];
				join_pc                    <= save_pc[rec.warp_num];
				save_valid[rec.warp_num]   <= 1'b0;
			end

			if (rec.is_barrier) begin
				if (bar_release) begin
					stall_mask <= stall_mask & ~(bar_waiters[rec.barrier_id] | warp_bit);
					bar_waiters[rec.barrier_id] <= '0;
					bar_count[rec.barrier_id]   <= '0;
				end else begin
					stall_mask <= stall_mask | warp_bit;
					bar_waiters[rec.barrier_id] <= bar_waiters[rec.barrier_id] | warp_bit;
					bar_count[rec.barrier_id]   <= bar_count[rec.barrier_id] + 1'b1;
				end
			end
		end
	end

	// saved mask and pc only matter while save_valid is set
	always_ff @(posedge clk) begin
		if (fire && do_split) begin
			save_mask[rec.warp_num] <= rec.split_later_mask;
			save_pc[rec.warp_num]   <= rec.split_save_pc;
		end
	end

endmodule

// File: hdl/warp_ctl_fifo.sv
`timescale 1ns/10ps

module warp_ctl_fifo
	import gpu_pkg::*;
#(
	parameter int DEPTH = 4
) (
	input  logic      clk,
	input  logic      arst_n,
	input  logic      in_valid,
	output logic      in_ready,
	input  warp_ctl_t in_rec,
	output logic      out_valid,
	input  logic      out_ready,
	output warp_ctl_t out_rec
);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	warp_ctl_t        mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             push;
	logic             pop;

	// wrap at DEPTH so non power of two depths work
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign out_valid = (count != '0);
	// full buffer still takes a write when the head leaves in the same cycle
	assign in_ready  = (count != CNT_W'(DEPTH)) || out_ready;
	assign push      = in_valid && in_ready;
	assign pop       = out_valid && out_ready;
	assign out_rec   = mem[rd_ptr];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) wr_ptr <= ptr_inc(wr_ptr);
			if (pop) rd_ptr <= ptr_inc(rd_ptr);
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push) mem[wr_ptr] <= in_rec;
	end

endmodule

// File: gpu_inst/gpu_inst_unit.sv
`timescale 1ns/10ps
`include "gpu_macros.svh"

module gpu_inst_unit
	import gpu_pkg::*;
(
	input  gpu_inst_req_t req,
	output warp_ctl_t     ctl
);
	thread_mask_t     curr_valids;
	logic             valid_inst;
	logic             is_tmc;
	logic             is_split;
	logic             all_threads;
	logic             all_active;
	thread_mask_t     tmc_new_mask;
	warp_mask_t       wspawn_new_active;
	thread_mask_t     split_new_use_mask;
	thread_mask_t     split_new_later_mask;
	logic [NT_BITS:0] num_valids;
	word_t            num_warps_m1;

	assign curr_valids = req.valid;
	assign valid_inst  = |curr_valids;
	assign is_tmc      = (req.op == op_tmc);
	assign is_split    = (req.op == op_split);

	// thread 0 operand is the thread / warp count for tmc and wspawn
	assign all_threads = req.a_reg_data[0] >= word_t'(`NUM_THREADS);
	assign all_active  = req.a_reg_data[0] >= word_t'(`NUM_WARPS);

	for (genvar t = 0; t < `NUM_THREADS; t++) begin : g_tmc_mask
		assign tmc_new_mask[t] = all_threads | (word_t'(t) < req.a_reg_data[0]);
	end

	for (genvar w = 0; w < `NUM_WARPS; w++) begin : g_wspawn_mask
		assign wspawn_new_active[w] = all_active | (word_t'(w) < req.a_reg_data[0]);
	end

	// split predicate is one per thread
	for (genvar t = 0; t < `NUM_THREADS; t++) begin : g_split_mask
		logic curr_bool;
		assign curr_bool                 = (req.a_reg_data[t] == 32'd1);
		assign split_new_use_mask[t]   = curr_valids[t] & curr_bool;
		assign split_new_later_mask[t] = curr_valids[t] & !curr_bool;
	end

	// ones-count of the valid threads
	always_comb begin
		num_valids = '0;
		for (int t = 0; t < `NUM_THREADS; t++) begin
			num_valids = num_valids + {{NT_BITS{1'b0}}, curr_valids[t]};
		end
	end

	// rd2 carries the number of warps taking part in the barrier
	assign num_warps_m1 = req.rd2 - 32'd1;

	assign ctl.warp_num    = req.warp_num;
	assign ctl.change_mask = is_tmc && valid_inst;
	assign ctl.thread_mask = is_tmc ? tmc_new_mask : '0;
	assign ctl.ebreak      = ctl.change_mask && (ctl.thread_mask == '0);

	assign ctl.wspawn            = (req.op == op_wspawn);
	assign ctl.wspawn_pc         = req.rd2;
	assign ctl.wspawn_new_active = wspawn_new_active;

	assign ctl.is_split         = is_split && (num_valids > 1);
	assign ctl.dont_split       = ctl.is_split && ((split_new_use_mask == '0) ||
	                                               (split_new_use_mask == '1));
	assign ctl.split_new_mask   = split_new_use_mask;
	assign ctl.split_later_mask = split_new_later_mask;
	assign ctl.split_save_pc    = req.pc_next;

	assign ctl.is_join = (req.op == op_join);

	assign ctl.is_barrier = (req.op == op_bar) && valid_inst;
	assign ctl.barrier_id = req.a_reg_data[0][NB_BITS-1:0];
	assign ctl.num_warps  = num_warps_m1[NW_BITS:0];

endmodule

// File: common/gpu_pkg.sv
`include "gpu_macros.svh"

package gpu_pkg;

	// index widths
	localparam int NT_BITS = $clog2(`NUM_THREADS);
	localparam int NW_BITS = $clog2(`NUM_WARPS);
	localparam int NB_BITS = $clog2(`NUM_BARRIERS);

	typedef logic [`NUM_THREADS-1:0] thread_mask_t;
	typedef logic [`NUM_WARPS-1:0]   warp_mask_t;
	typedef logic [NW_BITS-1:0]      warp_num_t;
	typedef logic [NB_BITS-1:0]      barrier_id_t;
	typedef logic [31:0]             word_t;

	typedef enum logic [2:0] {
		op_tmc,
		op_wspawn,
		op_split,
		op_join,
		op_bar
	} gpu_op_t;

	// one control instruction from the issue stage
	typedef struct packed {
		thread_mask_t                  valid;
		warp_num_t                     warp_num;
		gpu_op_t                       op;
		word_t [`NUM_THREADS-1:0]      a_reg_data;
		word_t                         rd2;
		word_t                         pc_next;
	} gpu_inst_req_t;

	// decoded warp-control record
	typedef struct packed {
		warp_num_t        warp_num;
		logic             change_mask;
		thread_mask_t     thread_mask;
		logic             ebreak;
		logic             wspawn;
		word_t            wspawn_pc;
		warp_mask_t       wspawn_new_active;
		logic             is_split;
		logic             dont_split;
		thread_mask_t     split_new_mask;
		thread_mask_t     split_later_mask;
		word_t            split_save_pc;
		logic             is_join;
		logic             is_barrier;
		barrier_id_t      barrier_id;
		logic [NW_BITS:0] num_warps;
	} warp_ctl_t;

endpackage

// File: common/gpu_macros.svh
`ifndef GPU_MACROS_SVH
`define GPU_MACROS_SVH

// threads per warp
`define NUM_THREADS 4

// warps in the core
`define NUM_WARPS 4

// named barriers
`define NUM_BARRIERS 4

// warp-control records buffered between decode and scheduler
`define CTL_FIFO_DEPTH 4

`endif
